//--- Makefile
# Verilator build and run of the extractor mux testbench

VERILATOR ?= verilator
TOP       ?= tb_nts_extractor_mux
FILELIST  ?= extractor_mux.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fails when the run fails"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- bench/engine_model.sv
// Behavioral engine array
// Each engine keeps a queue of packets and streams the head packet word
// by word after a FIFO read start, with random gaps between words

`timescale 1ns/1ps

module engine_model (
  input  logic                                                        i_clk,
  input  logic                                                        i_areset,
  input  logic                                                        i_push,
  input  extractor_pkg::engine_idx_t                                  i_push_engine,
  input  logic [extractor_pkg::ADDR_WIDTH-1:0]                        i_push_words,
  input  logic [extractor_pkg::LWDV_WIDTH-1:0]                        i_push_lwdv,
  input  logic [15:0]                                                 i_push_id,
  input  extractor_pkg::engine_ctrl_t   [extractor_pkg::ENGINES-1:0] i_engine_ctrl,
  output extractor_pkg::engine_status_t [extractor_pkg::ENGINES-1:0] o_engine_status
);

  typedef struct packed {
    logic [15:0]                          id;
    logic [extractor_pkg::ADDR_WIDTH-1:0] words;
    logic [extractor_pkg::LWDV_WIDTH-1:0] lwdv;
  } packet_t;

  packet_t     pkt_q [extractor_pkg::ENGINES][$];
  int          word_pos [extractor_pkg::ENGINES];
  logic        streaming [extractor_pkg::ENGINES];
  logic        drained [extractor_pkg::ENGINES];
  logic [31:0] lfsr;

  // Galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) return (state >> 1) ^ 32'h8020_0003;
    return state >> 1;
  endfunction

  always @(posedge i_clk or posedge i_areset) begin
    packet_t head;
    logic    take;
    if (i_areset) begin
      lfsr            = 32'h34e1;
      o_engine_status <= '0;
      for (int e = 0; e < extractor_pkg::ENGINES; e++) begin
        pkt_q[e].delete();
        word_pos[e]  = 0;
        streaming[e] = 1'b0;
        drained[e]   = 1'b0;
      end
    end else begin
      if (i_push) begin
        pkt_q[i_push_engine].push_back({i_push_id, i_push_words, i_push_lwdv});
      end
      for (int e = 0; e < extractor_pkg::ENGINES; e++) begin
        o_engine_status[e].fifo_rd_valid <= 1'b0;
        if (i_engine_ctrl[e].fifo_rd_start && pkt_q[e].size() > 0) begin
          streaming[e] = 1'b1;
          word_pos[e]  = 0;
        end else if (streaming[e]) begin
          // One LFSR bit per cycle decides word or gap
          take = lfsr[0];
          lfsr = lfsr_step(lfsr);
          if (take) begin
            head = pkt_q[e][0];
            o_engine_status[e].fifo_rd_valid <= 1'b1;
            o_engine_status[e].fifo_rd_data  <= {16'(e), head.id, 32'(word_pos[e])};
            word_pos[e] = word_pos[e] + 1;
            if (word_pos[e] == int'(head.words)) begin
              streaming[e] = 1'b0;
              drained[e]   = 1'b1;
            end
          end
        end
        if (i_engine_ctrl[e].packet_read && pkt_q[e].size() > 0) begin
          head       = pkt_q[e].pop_front();
          drained[e] = 1'b0;
        end
        o_engine_status[e].packet_available <= (pkt_q[e].size() > 0);
        o_engine_status[e].fifo_empty       <= (pkt_q[e].size() == 0) || drained[e];
        o_engine_status[e].bytes_last_word  <= (pkt_q[e].size() > 0) ? pkt_q[e][0].lwdv : '0;
      end
    end
  end

endmodule

//--- bench/tb_nts_extractor_mux.sv
// Testbench for the packet extractor mux
// Directed tests against a behavioral engine array, with a captured
// copy of the shared output buffer

`timescale 1ns/1ps

module tb_nts_extractor_mux;

  localparam int TOTAL_PACKETS  = 8;
  localparam int TIMEOUT_CYCLES = 200 * TOTAL_PACKETS;
  localparam int MAX_PACKETS    = 16;

  logic                                                       i_clk = 1'b0;
  logic                                                       i_areset;
  logic                                                       i_buffer_start;
  logic                                                       i_buffer_stop;
  extractor_pkg::engine_status_t [extractor_pkg::ENGINES-1:0] i_engine_status;
  extractor_pkg::engine_ctrl_t   [extractor_pkg::ENGINES-1:0] o_engine_ctrl;
  extractor_pkg::buffer_wr_t                                  o_buffer_wr;
  logic                                                       o_buffer_ready;
  logic [extractor_pkg::ADDR_WIDTH-1:0]                       o_buffer_length;
  logic [extractor_pkg::LWDV_WIDTH-1:0]                       o_buffer_lwdv;

  // Packet queue port of the engine model
  logic                                 push;
  extractor_pkg::engine_idx_t           push_engine;
  logic [extractor_pkg::ADDR_WIDTH-1:0] push_words;
  logic [extractor_pkg::LWDV_WIDTH-1:0] push_lwdv;
  logic [15:0]                          push_id;

  logic [extractor_pkg::DATA_WIDTH-1:0] buffer_mem [2**extractor_pkg::ADDR_WIDTH];
  int   pkt_engine [MAX_PACKETS];
  int   pkt_words [MAX_PACKETS];
  int   pkt_lwdv [MAX_PACKETS];
  logic pkt_done [MAX_PACKETS];
  int   next_id = 0;
  int   cycle_count = 0;

  always #2 i_clk = ~i_clk;

  nts_extractor_mux nts_extractor_mux_i (
    .i_clk,
    .i_areset,
    .i_engine_status,
    .o_engine_ctrl,
    .i_buffer_start,
    .i_buffer_stop,
    .o_buffer_wr,
    .o_buffer_ready,
    .o_buffer_length,
    .o_buffer_lwdv
  );

  engine_model engine_model_i (
    .i_clk           (i_clk),
    .i_areset        (i_areset),
    .i_push          (push),
    .i_push_engine   (push_engine),
    .i_push_words    (push_words),
    .i_push_lwdv     (push_lwdv),
    .i_push_id       (push_id),
    .i_engine_ctrl   (o_engine_ctrl),
    .o_engine_status (i_engine_status)
  );

  // Buffer memory copy
  always @(posedge i_clk) begin
    if (o_buffer_wr.en) buffer_mem[o_buffer_wr.addr] <= o_buffer_wr.data;
  end

  always @(posedge i_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
      $display("Timeout: no result after %0d cycles", TIMEOUT_CYCLES);
      stop_on_error();
    end
  end

  //------------------------------------------------------------
  // Checks
  //------------------------------------------------------------
  task automatic stop_on_error();
    $display("FAIL: see errors above");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic compare_word(input string name, input logic [extractor_pkg::DATA_WIDTH-1:0] exp,
                              input logic [extractor_pkg::DATA_WIDTH-1:0] act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic compare_length(input string name, input logic [extractor_pkg::ADDR_WIDTH-1:0] exp,
                                input logic [extractor_pkg::ADDR_WIDTH-1:0] act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected length %0d, actual %0d", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic compare_lwdv(input string name, input logic [extractor_pkg::LWDV_WIDTH-1:0] exp,
                              input logic [extractor_pkg::LWDV_WIDTH-1:0] act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected lwdv %0d, actual %0d", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic compare_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected flag %b, actual %b", name, exp, act);
      stop_on_error();
    end
  endtask

  // Engine number in the top 16 bits, packet id next, word position below
  function automatic logic [extractor_pkg::DATA_WIDTH-1:0] expected_word(input int engine,
                                                                      input int id, input int pos);
    return {16'(engine), 16'(id), 32'(pos)};
  endfunction

  task automatic check_buffer(input string name, input int id);
    compare_length(name, pkt_words[id][extractor_pkg::ADDR_WIDTH-1:0], o_buffer_length);
    compare_lwdv(name, pkt_lwdv[id][extractor_pkg::LWDV_WIDTH-1:0], o_buffer_lwdv);
    for (int i = 0; i < pkt_words[id]; i++) begin
      compare_word(name, expected_word(pkt_engine[id], id, i), buffer_mem[i]);
    end
    pkt_done[id] = 1'b1;
  endtask

  //------------------------------------------------------------
  // Stimulus helpers
  //------------------------------------------------------------
  task automatic queue_packet(input int engine, input int words, input int lwdv, output int id);
    id             = next_id;
    next_id        = next_id + 1;
    pkt_engine[id] = engine;
    pkt_words[id]  = words;
    pkt_lwdv[id]   = lwdv;
    pkt_done[id]   = 1'b0;
    @(posedge i_clk);
    push        <= 1'b1;
    push_engine <= engine[extractor_pkg::ENGINE_SEL_W-1:0];
    push_words  <= words[extractor_pkg::ADDR_WIDTH-1:0];
    push_lwdv   <= lwdv[extractor_pkg::LWDV_WIDTH-1:0];
    push_id     <= id[15:0];
    @(posedge i_clk);
    push <= 1'b0;
  endtask

  task automatic wait_ready();
    @(negedge i_clk);
    while (!o_buffer_ready) @(negedge i_clk);
  endtask

  task automatic pulse_consumer(input logic start, input logic stop);
    @(posedge i_clk);
    i_buffer_start <= start;
    i_buffer_stop  <= stop;
    @(posedge i_clk);
    i_buffer_start <= 1'b0;
    i_buffer_stop  <= 1'b0;
  endtask

  task automatic release_buffer();
    pulse_consumer(1'b1, 1'b0);
    pulse_consumer(1'b0, 1'b1);
  endtask

  //------------------------------------------------------------
  // Directed tests
  //------------------------------------------------------------
  task automatic idle_after_reset();
    repeat (10) begin
      @(negedge i_clk);
      compare_flag("after_reset", 1'b0, o_buffer_ready);
      compare_length("after_reset", '0, o_buffer_length);
      compare_flag("after_reset", 1'b0, |o_engine_ctrl);
    end
  endtask

  task automatic single_packet();
    int id;
    queue_packet(2, 5, 3, id);
    wait_ready();
    check_buffer("single_packet", id);
    release_buffer();
  endtask

  task automatic back_pressure();
    int first_id;
    int second_id;
    queue_packet(1, 3, 8, first_id);
    wait_ready();
    queue_packet(3, 4, 1, second_id);
    // Engine 3 is ready but the buffer stays loaded
    repeat (40) begin
      @(negedge i_clk);
      compare_flag("back_pressure", 1'b0, o_engine_ctrl[3].fifo_rd_start);
    end
    check_buffer("back_pressure", first_id);
    release_buffer();
    wait_ready();
    check_buffer("back_pressure", second_id);
    release_buffer();
  endtask

  task automatic all_engines();
    int ids [extractor_pkg::ENGINES];
    int engine_field;
    int match;
    for (int e = 0; e < extractor_pkg::ENGINES; e++) begin
      queue_packet(e, 2 + e, e + 1, ids[e]);
    end
    for (int n = 0; n < extractor_pkg::ENGINES; n++) begin
      wait_ready();
      engine_field = int'(buffer_mem[0][63:48]);
      match        = -1;
      for (int e = 0; e < extractor_pkg::ENGINES; e++) begin
        if (pkt_engine[ids[e]] == engine_field && !pkt_done[ids[e]]) match = ids[e];
      end
      if (match < 0) begin
        $display("all_engines: buffer holds no pending packet of engine %0d", engine_field);
        stop_on_error();
      end
      check_buffer("all_engines", match);
      release_buffer();
    end
    // No engine holds a packet now and no read may start again
    repeat (40) begin
      @(negedge i_clk);
      compare_flag("all_engines", 1'b0, o_buffer_ready);
      for (int e = 0; e < extractor_pkg::ENGINES; e++) begin
        compare_flag("all_engines", 1'b0, o_engine_ctrl[e].fifo_rd_start);
      end
    end
  endtask

  task automatic start_drops_ready();
    int id;
    queue_packet(0, 6, 5, id);
    wait_ready();
    check_buffer("buffer_start", id);
    pulse_consumer(1'b1, 1'b0);
    @(negedge i_clk);
    compare_flag("buffer_start", 1'b0, o_buffer_ready);
    check_buffer("buffer_start", id);
    pulse_consumer(1'b0, 1'b1);
  endtask

  initial begin
    i_areset       = 1'b1;
    i_buffer_start = 1'b0;
    i_buffer_stop  = 1'b0;
    push           = 1'b0;
    push_engine    = '0;
    push_words     = '0;
    push_lwdv      = '0;
    push_id        = '0;
    repeat (5) @(posedge i_clk);
    i_areset <= 1'b0;
    idle_after_reset();
    single_packet();
    back_pressure();
    all_engines();
    start_drops_ready();
    $display("PASS: all tests");
    $finish;
  end

endmodule

//--- design/buffer_writer.sv
// Buffer writer
// Owns the shared output buffer state and write address, turns reader
// words into memory writes and reports length and readiness

`timescale 1ns/1ps

module buffer_writer (
  input  logic                                 i_clk,
  input  logic                                 i_areset,
  input  extractor_pkg::reader_xfer_t          i_xfer,
  input  logic                                 i_buffer_start,
  input  logic                                 i_buffer_stop,
  output logic                                 o_buffer_free,
  output extractor_pkg::buffer_wr_t            o_buffer_wr,
  output logic                                 o_buffer_ready,
  output logic [extractor_pkg::ADDR_WIDTH-1:0] o_buffer_length,
  output logic [extractor_pkg::LWDV_WIDTH-1:0] o_buffer_lwdv
);

  extractor_pkg::buffer_state_t         state_reg;
  extractor_pkg::buffer_state_t         state_new;
  logic [extractor_pkg::ADDR_WIDTH-1:0] addr_reg;
  logic [extractor_pkg::ADDR_WIDTH-1:0] addr_new;
  logic [extractor_pkg::LWDV_WIDTH-1:0] lwdv_reg;
  logic [extractor_pkg::LWDV_WIDTH-1:0] lwdv_new;

  assign o_buffer_free   = (state_reg == extractor_pkg::UNUSED);
  assign o_buffer_ready  = (state_reg == extractor_pkg::LOADED);
  assign o_buffer_length = addr_reg;
  assign o_buffer_lwdv   = lwdv_reg;

  //------------------------------------------------------------
  // Buffer state and write port
  //------------------------------------------------------------
  always_comb begin
    state_new   = state_reg;
    addr_new    = addr_reg;
    lwdv_new    = lwdv_reg;
    o_buffer_wr = '0;
    case (state_reg)
      extractor_pkg::UNUSED: begin
        if (i_xfer.start) begin
          state_new = extractor_pkg::WRITING;
          addr_new  = '0;
          lwdv_new  = i_xfer.lwdv;
        end
      end
      extractor_pkg::WRITING: begin
        if (i_xfer.data_valid) begin
          o_buffer_wr.en   = 1'b1;
          o_buffer_wr.addr = addr_reg;
          o_buffer_wr.data = i_xfer.data;
          addr_new         = addr_reg + 1'b1;
        end else if (i_xfer.stop) begin
          state_new = extractor_pkg::LOADED;
        end
      end
      default: ;
    endcase
    // Consumer requests, start has the last word
    if (i_buffer_stop) state_new = extractor_pkg::UNUSED;
    if (i_buffer_start) state_new = extractor_pkg::READING;
  end

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      state_reg <= extractor_pkg::UNUSED;
      addr_reg  <= '0;
      lwdv_reg  <= '0;
    end else begin
      state_reg <= state_new;
      addr_reg  <= addr_new;
      lwdv_reg  <= lwdv_new;
    end
  end

endmodule

//--- design/engine_arbiter.sv
// Engine arbiter
// Rotating search for an engine with a packet ready, and the mux that
// connects the selected engine to the reader

`timescale 1ns/1ps

module engine_arbiter (
  input  logic                                                        i_clk,
  input  logic                                                        i_areset,
  input  extractor_pkg::engine_status_t [extractor_pkg::ENGINES-1:0] i_engine_status,
  output extractor_pkg::engine_ctrl_t   [extractor_pkg::ENGINES-1:0] o_engine_ctrl,
  input  extractor_pkg::engine_ctrl_t                                 i_reader_ctrl,
  output extractor_pkg::engine_status_t                               o_sel_status
);

  localparam extractor_pkg::engine_idx_t ENGINE_LAST =
    extractor_pkg::engine_idx_t'(extractor_pkg::ENGINES - 1);

  typedef enum logic {
    MUX_SEARCH = 1'b0,
    MUX_REMAIN = 1'b1
  } mux_mode_t;

  logic [extractor_pkg::ENGINES-1:0] ready_mask_reg;
  extractor_pkg::engine_idx_t        ready_idx_reg;
  extractor_pkg::engine_idx_t        ready_idx_new;
  logic                              ready_found_reg;
  logic                              ready_found_new;
  logic                              start_search;

  mux_mode_t                         mode_reg;
  mux_mode_t                         mode_new;
  extractor_pkg::engine_idx_t        sel_idx_reg;
  extractor_pkg::engine_idx_t        sel_idx_new;
  extractor_pkg::engine_status_t     sel_engine;

  assign sel_engine = i_engine_status[sel_idx_reg];

  //------------------------------------------------------------
  // Ready search
  //------------------------------------------------------------
  // Index walks downward and parks on a ready engine that is not the one in service
  always_comb begin
    logic found;
    found = ready_mask_reg[ready_idx_reg];
    if (ready_idx_reg == sel_idx_reg && mode_reg == MUX_REMAIN) begin
      found = 1'b0;
    end
    ready_found_new = found && !start_search;
    if (found) begin
      ready_idx_new = ready_idx_reg;
    end else if (ready_idx_reg == '0) begin
      ready_idx_new = ENGINE_LAST;
    end else begin
      ready_idx_new = ready_idx_reg - 1'b1;
    end
  end

  //------------------------------------------------------------
  // Selection mux
  //------------------------------------------------------------
  always_comb begin
    logic advance;
    advance      = 1'b0;
    start_search = 1'b0;
    mode_new     = mode_reg;
    sel_idx_new  = sel_idx_reg;
    o_sel_status = '0;
    case (mode_reg)
      MUX_REMAIN: begin
        o_sel_status = sel_engine;
        // Packet done, hand over to whatever the search found
        if (i_reader_ctrl.packet_read) begin
          advance  = 1'b1;
          mode_new = MUX_SEARCH;
        end
      end
      default: begin
        if (sel_engine.packet_available) begin
          mode_new     = MUX_REMAIN;
          start_search = 1'b1;
        end else begin
          advance = 1'b1;
        end
      end
    endcase
    if (advance && ready_found_reg) begin
      sel_idx_new = ready_idx_reg;
    end
  end

  // Reader pulses reach the selected engine only
  always_comb begin
    o_engine_ctrl              = '0;
    o_engine_ctrl[sel_idx_reg] = i_reader_ctrl;
  end

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      ready_mask_reg  <= '0;
      ready_idx_reg   <= '0;
      ready_found_reg <= 1'b0;
      mode_reg        <= MUX_SEARCH;
      sel_idx_reg     <= '0;
    end else begin
      for (int i = 0; i < extractor_pkg::ENGINES; i++) begin
        ready_mask_reg[i] <= i_engine_status[i].packet_available &&
                             !i_engine_status[i].fifo_empty;
      end
      ready_idx_reg   <= ready_idx_new;
      ready_found_reg <= ready_found_new;
      mode_reg        <= mode_new;
      sel_idx_reg     <= sel_idx_new;
    end
  end

endmodule

//--- design/engine_reader.sv
// Engine reader
// Registers the selected engine's status one stage, then pulls one
// packet out of its read FIFO and hands the words to the buffer writer

`timescale 1ns/1ps

module engine_reader (
  input  logic                          i_clk,
  input  logic                          i_areset,
  input  extractor_pkg::engine_status_t i_sel_status,
  input  logic                          i_buffer_free,
  output extractor_pkg::engine_ctrl_t   o_reader_ctrl,
  output extractor_pkg::reader_xfer_t   o_xfer
);

  typedef enum logic [1:0] {
    IDLE    = 2'b00,
    START   = 2'b01,
    READING = 2'b10,
    STOP    = 2'b11
  } reader_state_t;

  reader_state_t state_reg;
  reader_state_t state_new;

  // Input delay stage
  logic                                delay_ready_reg;
  logic                                delay_valid_reg;
  logic                                delay_empty_reg;
  logic [extractor_pkg::DATA_WIDTH-1:0] delay_data_reg;
  logic [extractor_pkg::LWDV_WIDTH-1:0] delay_lwdv_reg;

  // Registered outputs
  logic                                rd_start_reg;
  logic                                packet_read_reg;
  logic                                start_reg;
  logic                                stop_reg;
  logic                                data_valid_reg;
  logic [extractor_pkg::DATA_WIDTH-1:0] data_reg;
  logic [extractor_pkg::LWDV_WIDTH-1:0] lwdv_reg;

  assign o_reader_ctrl.packet_read   = packet_read_reg;
  assign o_reader_ctrl.fifo_rd_start = rd_start_reg;

  assign o_xfer.start      = start_reg;
  assign o_xfer.stop       = stop_reg;
  assign o_xfer.data_valid = data_valid_reg;
  assign o_xfer.data       = data_reg;
  assign o_xfer.lwdv       = lwdv_reg;

  //------------------------------------------------------------
  // Reader FSM
  //------------------------------------------------------------
  always_comb begin
    state_new = state_reg;
    case (state_reg)
      IDLE:    if (i_buffer_free && delay_ready_reg) state_new = START;
      START:   state_new = READING;
      READING: begin
        // A valid word takes priority over empty
        if (!delay_valid_reg && delay_empty_reg) begin
          state_new = STOP;
        end
      end
      default: state_new = IDLE;
    endcase
  end

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      delay_ready_reg <= 1'b0;
      delay_valid_reg <= 1'b0;
      delay_empty_reg <= 1'b0;
      state_reg       <= IDLE;
      rd_start_reg    <= 1'b0;
      packet_read_reg <= 1'b0;
      start_reg       <= 1'b0;
      stop_reg        <= 1'b0;
      data_valid_reg  <= 1'b0;
    end else begin
      delay_ready_reg <= i_sel_status.packet_available && !i_sel_status.fifo_empty;
      delay_valid_reg <= i_sel_status.fifo_rd_valid;
      delay_empty_reg <= i_sel_status.fifo_empty;
      state_reg       <= state_new;
      rd_start_reg    <= (state_reg == START);
      start_reg       <= (state_reg == START);
      packet_read_reg <= (state_reg == STOP);
      stop_reg        <= (state_reg == STOP);
      data_valid_reg  <= (state_reg == READING) && delay_valid_reg;
    end
  end

  // Payload path
  always_ff @(posedge i_clk) begin
    delay_data_reg <= i_sel_status.fifo_rd_data;
    delay_lwdv_reg <= i_sel_status.bytes_last_word;
    if (state_reg == READING && delay_valid_reg) begin
      data_reg <= delay_data_reg;
    end
    if (state_reg == START) begin
      lwdv_reg <= delay_lwdv_reg;
    end
  end

endmodule

//--- design/extractor_pkg.sv
// Extractor mux shared definitions
// Widths, engine count, buffer state encoding and the bundles that
// travel between the engines, the arbiter, the reader and the buffer

package extractor_pkg;

  //------------------------------------------------------------
  // Sizes
  //------------------------------------------------------------
  localparam int ENGINES      = 4;
  localparam int ENGINE_SEL_W = (ENGINES > 1) ? $clog2(ENGINES) : 1;
  localparam int ADDR_WIDTH   = 8;
  localparam int DATA_WIDTH   = 64;
  // Byte count of the last word, 1 to 8
  localparam int LWDV_WIDTH   = 4;

  typedef logic [ENGINE_SEL_W-1:0] engine_idx_t;

  //------------------------------------------------------------
  // Engine side
  //------------------------------------------------------------
  typedef struct packed {
    logic                  packet_available;
    logic                  fifo_empty;
    logic                  fifo_rd_valid;
    logic [DATA_WIDTH-1:0] fifo_rd_data;
    logic [LWDV_WIDTH-1:0] bytes_last_word;
  } engine_status_t;

  typedef struct packed {
    logic packet_read;    // Packet consumed, engine may discard it
    logic fifo_rd_start;  // Start streaming words
  } engine_ctrl_t;

  //------------------------------------------------------------
  // Reader to buffer writer, and buffer memory port
  //------------------------------------------------------------
  typedef struct packed {
    logic                  start;
    logic                  stop;
    logic                  data_valid;
    logic [DATA_WIDTH-1:0] data;
    logic [LWDV_WIDTH-1:0] lwdv;
  } reader_xfer_t;

  typedef struct packed {
    logic                  en;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] data;
  } buffer_wr_t;

  typedef enum logic [1:0] {
    UNUSED  = 2'b00,
    WRITING = 2'b01,
    LOADED  = 2'b10,
    READING = 2'b11
  } buffer_state_t;

endpackage

//--- design/nts_extractor_mux.sv
// Packet extractor mux top level
// Several engines share one output buffer through a round-robin arbiter,
// a packet reader and the buffer writer

`timescale 1ns/1ps

module nts_extractor_mux (
  input  logic                                                        i_clk,
  input  logic                                                        i_areset,

  input  extractor_pkg::engine_status_t [extractor_pkg::ENGINES-1:0] i_engine_status,
  output extractor_pkg::engine_ctrl_t   [extractor_pkg::ENGINES-1:0] o_engine_ctrl,

  input  logic                                                        i_buffer_start,
  input  logic                                                        i_buffer_stop,

  output extractor_pkg::buffer_wr_t                                   o_buffer_wr,
  output logic                                                        o_buffer_ready,
  output logic                          [extractor_pkg::ADDR_WIDTH-1:0] o_buffer_length,
  output logic                          [extractor_pkg::LWDV_WIDTH-1:0] o_buffer_lwdv
);

  extractor_pkg::engine_status_t sel_status;
  extractor_pkg::engine_ctrl_t   reader_ctrl;
  extractor_pkg::reader_xfer_t   xfer;
  logic                          buffer_free;

  engine_arbiter engine_arbiter_i (
    .i_clk           (i_clk),
    .i_areset        (i_areset),
    .i_engine_status (i_engine_status),
    .o_engine_ctrl   (o_engine_ctrl),
    .i_reader_ctrl   (reader_ctrl),
    .o_sel_status    (sel_status)
  );

  engine_reader engine_reader_i (
    .i_clk         (i_clk),
    .i_areset      (i_areset),
    .i_sel_status  (sel_status),
    .i_buffer_free (buffer_free),
    .o_reader_ctrl (reader_ctrl),
    .o_xfer        (xfer)
  );

  buffer_writer buffer_writer_i (
    .i_clk           (i_clk),
    .i_areset        (i_areset),
    .i_xfer          (xfer),
    .i_buffer_start  (i_buffer_start),
    .i_buffer_stop   (i_buffer_stop),
    .o_buffer_free   (buffer_free),
    .o_buffer_wr     (o_buffer_wr),
    .o_buffer_ready  (o_buffer_ready),
    .o_buffer_length (o_buffer_length),
    .o_buffer_lwdv   (o_buffer_lwdv)
  );

endmodule

//--- extractor_mux.f
design/extractor_pkg.sv
design/engine_arbiter.sv
design/engine_reader.sv
design/buffer_writer.sv
design/nts_extractor_mux.sv
bench/engine_model.sv
bench/tb_nts_extractor_mux.sv
